//--- design/alu.sv
`timescale 1ns/1ps

module alu (
	input mipsPkg::aluOpE op_i,
	input mipsPkg::wordT srcA_i,
	input mipsPkg::wordT srcB_i,
	output mipsPkg::wordT result_o,
	output logic zero_o
);

	always_comb begin
		case (op_i)
			mipsPkg::aluAdd: result_o = srcA_i + srcB_i;
			mipsPkg::aluSub: result_o = srcA_i - srcB_i;
			mipsPkg::aluAnd: result_o = srcA_i & srcB_i;
			mipsPkg::aluOr: result_o = srcA_i | srcB_i;
			mipsPkg::aluSlt: begin
				// signed compare
				result_o = ($signed(srcA_i) < $signed(srcB_i)) ? 32'd1 : 32'd0;
			end
			mipsPkg::aluLui: result_o = {srcB_i[15:0], 16'b0};
			default: result_o = '0;
		endcase
	end

	// Used by beq through aluSub
	assign zero_o = (result_o == '0);

endmodule

//--- design/decoder.sv
`timescale 1ns/1ps

module decoder (
	input mipsPkg::wordT instr_i,
	output mipsPkg::ctrlT ctrl_o
);

	always_comb begin
		// Anything not matched below stays a bubble
		ctrl_o = '0;
		case (instr_i[31:26])
			mipsPkg::opRType: begin
				ctrl_o.regWrite = 1'b1;
				ctrl_o.dstIsRd = 1'b1;
				ctrl_o.srcB = mipsPkg::srcBReg;
				case (instr_i[5:0])
					mipsPkg::fnAddu: ctrl_o.aluOp = mipsPkg::aluAdd;
					mipsPkg::fnSubu: ctrl_o.aluOp = mipsPkg::aluSub;
					mipsPkg::fnAnd: ctrl_o.aluOp = mipsPkg::aluAnd;
					mipsPkg::fnOr: ctrl_o.aluOp = mipsPkg::aluOr;
					mipsPkg::fnSlt: ctrl_o.aluOp = mipsPkg::aluSlt;
					default: begin
						ctrl_o.regWrite = 1'b0;
						ctrl_o.dstIsRd = 1'b0;
					end
				endcase
			end
			mipsPkg::opAddiu: begin
				ctrl_o.regWrite = 1'b1;
				ctrl_o.srcB = mipsPkg::srcBSext;
				ctrl_o.aluOp = mipsPkg::aluAdd;
			end
			mipsPkg::opOri: begin
				ctrl_o.regWrite = 1'b1;
				ctrl_o.srcB = mipsPkg::srcBZext;
				ctrl_o.aluOp = mipsPkg::aluOr;
			end
			mipsPkg::opLui: begin
				ctrl_o.regWrite = 1'b1;
				ctrl_o.srcB = mipsPkg::srcBZext;
				ctrl_o.aluOp = mipsPkg::aluLui;
			end
			mipsPkg::opLw: begin
				ctrl_o.regWrite = 1'b1;
				ctrl_o.srcB = mipsPkg::srcBSext;
				ctrl_o.aluOp = mipsPkg::aluAdd;
				ctrl_o.memRead = 1'b1;
				ctrl_o.memToReg = 1'b1;
			end
			mipsPkg::opSw: begin
				ctrl_o.srcB = mipsPkg::srcBSext;
				ctrl_o.aluOp = mipsPkg::aluAdd;
				ctrl_o.memWrite = 1'b1;
			end
			mipsPkg::opBeq: begin
				// Compare by subtract, zero flag decides
				ctrl_o.srcB = mipsPkg::srcBReg;
				ctrl_o.aluOp = mipsPkg::aluSub;
				ctrl_o.branch = 1'b1;
			end
			default: ctrl_o = '0;
		endcase
	end

endmodule

//--- design/forwardUnit.sv
`timescale 1ns/1ps

module forwardUnit (
	input mipsPkg::idExT idEx_i,
	input mipsPkg::exMemT exMem_i,
	input mipsPkg::memWbT memWb_i,
	output mipsPkg::fwdSelE fwdA_o,
	output mipsPkg::fwdSelE fwdB_o,
	output mipsPkg::fwdSelE fwdStore_o
);

	// Younger result wins, r0 never forwarded
	function automatic mipsPkg::fwdSelE pickSrc(mipsPkg::regIdxT src);
		if (src == '0)
			return mipsPkg::fwdReg;
		// Load data is not ready in EX/MEM, the stall covers that case
		if (exMem_i.regWrite && !exMem_i.memRead && exMem_i.dst == src)
			return mipsPkg::fwdExMem;
		if (memWb_i.regWrite && memWb_i.dst == src)
			return mipsPkg::fwdMemWb;
		return mipsPkg::fwdReg;
	endfunction

	always_comb fwdA_o = pickSrc(idEx_i.rs);

	// Immediate operands need no forwarding
	always_comb fwdB_o = (idEx_i.ctrl.srcB == mipsPkg::srcBReg) ? pickSrc(idEx_i.rt)
		: mipsPkg::fwdReg;

	always_comb fwdStore_o = pickSrc(idEx_i.rt);

endmodule

//--- design/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit (
	input mipsPkg::idExT idEx_i,
	input mipsPkg::ifIdT ifId_i,
	input logic branchTaken_i,
	output logic stall_o,
	output logic flush_o
);

	mipsPkg::regIdxT decRs;
	mipsPkg::regIdxT decRt;
	logic loadUse;

	assign decRs = ifId_i.instr[25:21];
	assign decRt = ifId_i.instr[20:16];

	// Load in execute feeding the instruction in decode
	assign loadUse = idEx_i.ctrl.memRead && ifId_i.valid && idEx_i.dst != '0
		&& (idEx_i.dst == decRs || idEx_i.dst == decRt);

	// A taken branch kills the decode instruction anyway
	assign flush_o = branchTaken_i;
	assign stall_o = loadUse && !branchTaken_i;

endmodule

//--- design/mips.sv
`timescale 1ns/1ps

module mips #(
	parameter mipsPkg::wordT resetPc = '0
) (
	input logic clk_i,
	input logic rstN_i,
	input mipsPkg::wordT instr_i,
	input mipsPkg::wordT dataRd_i,
	output mipsPkg::wordT pcO_o,
	output mipsPkg::memReqT memReq_o
);

	mipsPkg::wordT pc;
	mipsPkg::ifIdT ifId;
	mipsPkg::idExT idEx;
	mipsPkg::exMemT exMem;
	mipsPkg::memWbT memWb;

	mipsPkg::ctrlT decCtrl;
	mipsPkg::wordT rsVal;
	mipsPkg::wordT rtVal;
	mipsPkg::wordT immExt;
	logic stall;
	logic flush;
	logic branchTaken;
	mipsPkg::fwdSelE fwdA;
	mipsPkg::fwdSelE fwdB;
	mipsPkg::fwdSelE fwdStore;
	mipsPkg::wordT opA;
	mipsPkg::wordT opBReg;
	mipsPkg::wordT opB;
	mipsPkg::wordT storeData;
	mipsPkg::wordT aluResult;
	logic aluZero;
	mipsPkg::wordT branchTarget;
	mipsPkg::wordT wbData;

	function automatic mipsPkg::wordT fwdMux(mipsPkg::fwdSelE sel, mipsPkg::wordT regVal);
		case (sel)
			mipsPkg::fwdExMem: return exMem.aluResult;
			mipsPkg::fwdMemWb: return wbData;
			default: return regVal;
		endcase
	endfunction

	// Fetch
	assign pcO_o = pc;

	always_ff @(posedge clk_i) begin
		if (!rstN_i)
			pc <= resetPc;
		else if (flush)
			pc <= branchTarget;
		else if (!stall)
			pc <= pc + 32'd4;
	end

	always_ff @(posedge clk_i) begin
		if (!rstN_i || flush) begin
			ifId <= '0;
		end else if (!stall) begin
			ifId.valid <= 1'b1;
			ifId.pcPlus4 <= pc + 32'd4;
			ifId.instr <= instr_i;
		end
	end

	// Decode
	decoder uDecoder (.instr_i(ifId.instr), .ctrl_o(decCtrl));

	regFile uRegFile (
		.clk_i(clk_i),
		.rstN_i(rstN_i),
		.rdAddrA_i(ifId.instr[25:21]),
		.rdAddrB_i(ifId.instr[20:16]),
		.wrEn_i(memWb.regWrite),
		.wrAddr_i(memWb.dst),
		.wrData_i(wbData),
		.rdDataA_o(rsVal),
		.rdDataB_o(rtVal)
	);

	assign immExt = (decCtrl.srcB == mipsPkg::srcBZext) ? {16'b0, ifId.instr[15:0]}
		: {{16{ifId.instr[15]}}, ifId.instr[15:0]};

	hazardUnit uHazard (
		.idEx_i(idEx),
		.ifId_i(ifId),
		.branchTaken_i(branchTaken),
		.stall_o(stall),
		.flush_o(flush)
	);

	// Stall and flush both insert a bubble here
	always_ff @(posedge clk_i) begin
		if (!rstN_i || flush || stall) begin
			idEx <= '0;
		end else begin
			idEx.ctrl <= decCtrl;
			idEx.pcPlus4 <= ifId.pcPlus4;
			idEx.rs <= ifId.instr[25:21];
			idEx.rt <= ifId.instr[20:16];
			idEx.dst <= decCtrl.dstIsRd ? ifId.instr[15:11] : ifId.instr[20:16];
			idEx.rsVal <= rsVal;
			idEx.rtVal <= rtVal;
			idEx.imm <= immExt;
		end
	end

	// Execute
	forwardUnit uForward (
		.idEx_i(idEx),
		.exMem_i(exMem),
		.memWb_i(memWb),
		.fwdA_o(fwdA),
		.fwdB_o(fwdB),
		.fwdStore_o(fwdStore)
	);

	always_comb opA = fwdMux(fwdA, idEx.rsVal);
	always_comb opBReg = fwdMux(fwdB, idEx.rtVal);
	assign opB = (idEx.ctrl.srcB == mipsPkg::srcBReg) ? opBReg : idEx.imm;
	always_comb storeData = fwdMux(fwdStore, idEx.rtVal);

	alu uAlu (.op_i(idEx.ctrl.aluOp), .srcA_i(opA), .srcB_i(opB), .result_o(aluResult),
		.zero_o(aluZero));

	assign branchTaken = idEx.ctrl.branch && aluZero;
	assign branchTarget = idEx.pcPlus4 + {idEx.imm[29:0], 2'b00};

	always_ff @(posedge clk_i) begin
		if (!rstN_i) begin
			exMem <= '0;
		end else begin
			exMem.regWrite <= idEx.ctrl.regWrite;
			exMem.memRead <= idEx.ctrl.memRead;
			exMem.memWrite <= idEx.ctrl.memWrite;
			exMem.memToReg <= idEx.ctrl.memToReg;
			exMem.dst <= idEx.dst;
			exMem.aluResult <= aluResult;
			exMem.storeData <= storeData;
		end
	end

	// Memory stage with the data read back in the same cycle
	assign memReq_o.write = exMem.memWrite;
	assign memReq_o.addr = exMem.aluResult;
	assign memReq_o.wdata = exMem.storeData;

	always_ff @(posedge clk_i) begin
		if (!rstN_i) begin
			memWb <= '0;
		end else begin
			memWb.regWrite <= exMem.regWrite;
			memWb.memToReg <= exMem.memToReg;
			memWb.dst <= exMem.dst;
			memWb.aluResult <= exMem.aluResult;
			memWb.loadData <= dataRd_i;
		end
	end

	// Writeback
	assign wbData = memWb.memToReg ? memWb.loadData : memWb.aluResult;

endmodule

//--- design/mipsPkg.sv
package mipsPkg;

	localparam int xlen = 32;
	localparam int regAddrW = 5;

	typedef logic [xlen-1:0] wordT;
	typedef logic [regAddrW-1:0] regIdxT;

	// Major opcode, bits 31:26
	typedef enum logic [5:0] {
		opRType = 6'h00,
		opBeq   = 6'h04,
		opAddiu = 6'h09,
		opOri   = 6'h0d,
		opLui   = 6'h0f,
		opLw    = 6'h23,
		opSw    = 6'h2b
	} opcodeE;

	// R-type funct, bits 5:0
	typedef enum logic [5:0] {
		fnAddu = 6'h21,
		fnSubu = 6'h23,
		fnAnd  = 6'h24,
		fnOr   = 6'h25,
		fnSlt  = 6'h2a
	} functE;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt,
		aluLui
	} aluOpE;

	// Zero vs sign extension is chosen in decode
	typedef enum logic [1:0] {
		srcBReg,
		srcBSext,
		srcBZext
	} srcBE;

	typedef enum logic [1:0] {
		fwdReg,
		fwdMemWb,
		fwdExMem
	} fwdSelE;

	typedef struct packed {
		logic regWrite;
		logic dstIsRd;
		srcBE srcB;
		aluOpE aluOp;
		logic memRead;
		logic memWrite;
		logic memToReg;
		logic branch;
	} ctrlT;

	typedef struct packed {
		logic valid;
		wordT pcPlus4;
		wordT instr;
	} ifIdT;

	typedef struct packed {
		ctrlT ctrl;
		wordT pcPlus4;
		regIdxT rs;
		regIdxT rt;
		regIdxT dst;
		wordT rsVal;
		wordT rtVal;
		wordT imm;
	} idExT;

	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic memToReg;
		regIdxT dst;
		wordT aluResult;
		wordT storeData;
	} exMemT;

	typedef struct packed {
		logic regWrite;
		logic memToReg;
		regIdxT dst;
		wordT aluResult;
		wordT loadData;
	} memWbT;

	typedef struct packed {
		logic write;
		wordT addr;
		wordT wdata;
	} memReqT;

endpackage

//--- design/regFile.sv
`timescale 1ns/1ps

module regFile (
	input logic clk_i,
	input logic rstN_i,
	input mipsPkg::regIdxT rdAddrA_i,
	input mipsPkg::regIdxT rdAddrB_i,
	input logic wrEn_i,
	input mipsPkg::regIdxT wrAddr_i,
	input mipsPkg::wordT wrData_i,
	output mipsPkg::wordT rdDataA_o,
	output mipsPkg::wordT rdDataB_o
);

	// Register 0 has no storage
	mipsPkg::wordT regs [1:(2**mipsPkg::regAddrW)-1];

	function automatic mipsPkg::wordT readPort(mipsPkg::regIdxT addr);
		if (addr == '0)
			return '0;
		// Same-cycle write bypass
		if (wrEn_i && wrAddr_i == addr)
			return wrData_i;
		return regs[addr];
	endfunction

	always_ff @(posedge clk_i) begin
		if (!rstN_i) begin
			for (int i = 1; i < 2**mipsPkg::regAddrW; i++)
				regs[i] <= '0;
		end else if (wrEn_i && wrAddr_i != '0) begin
			regs[wrAddr_i] <= wrData_i;
		end
	end

	always_comb rdDataA_o = readPort(rdAddrA_i);
	always_comb rdDataB_o = readPort(rdAddrB_i);

endmodule

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tbMips -f tb.f -o simTbMips
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

simOut="$(./obj_dir/simTbMips)"
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if echo "$simOut" | grep -qx "Test completed successfully"; then
	exit 0
fi
exit 1

//--- sim/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
	parameter int periodNs = 40,
	parameter int resetCycles = 4
) (
	output logic clk_o,
	output logic rstN_o
);

	initial begin
		clk_o = 1'b0;
		forever #(periodNs / 2) clk_o = ~clk_o;
	end

	// Release reset on a rising edge
	initial begin
		rstN_o = 1'b0;
		repeat (resetCycles) @(posedge clk_o);
		rstN_o <= 1'b1;
	end

endmodule

//--- sim/mipsAsserts.sv
`timescale 1ns/1ps

module mipsAsserts (
	input logic clk_i,
	input logic rstN_i,
	input mipsPkg::memReqT memReq_i,
	input logic stall_i,
	input logic flush_i,
	input mipsPkg::wordT pc_i,
	input mipsPkg::wordT target_i,
	input mipsPkg::idExT idEx_i
);

	// No data write leaves the core while reset is held
	noWriteInReset: assert property (@(posedge clk_i) !rstN_i |-> !memReq_i.write)
		else $error("Data memory write during reset");

	// PC follows the branch target even when a stall comes with the flush
	flushWins: assert property (@(posedge clk_i) disable iff (!rstN_i)
		(stall_i || flush_i) |=> pc_i == ($past(flush_i) ? $past(target_i) : $past(pc_i)))
		else $error("PC did not follow the flush over the stall");

	// Instruction behind a taken branch must not reach execute
	flushBubble: assert property (@(posedge clk_i) disable iff (!rstN_i)
		flush_i |=> (!idEx_i.ctrl.regWrite && !idEx_i.ctrl.memWrite && !idEx_i.ctrl.branch))
		else $error("ID/EX holds a live instruction after a flush");

endmodule

//--- sim/tbMips.sv
`timescale 1ns/1ps

module tbMips;

	typedef mipsPkg::memReqT reqListT[$];

	localparam mipsPkg::wordT bootPc = 32'h0000_0008;
	localparam int bootIdx = 2;

	logic clk;
	logic rstN;
	mipsPkg::wordT instr;
	mipsPkg::wordT dataRd;
	mipsPkg::wordT pcO;
	mipsPkg::memReqT memReq;

	mipsPkg::wordT imem [64];
	mipsPkg::wordT dmem [64];
	mipsPkg::functE fnList [5] = '{mipsPkg::fnAddu, mipsPkg::fnSubu, mipsPkg::fnAnd,
		mipsPkg::fnOr, mipsPkg::fnSlt};
	reqListT expQ;
	int progLen = 0;
	int storeSlot = 128;
	int expCount = 0;
	int storesSeen = 0;
	int mismatches = 0;
	int otherErrors = 0;

	clockGen uClock (.clk_o(clk), .rstN_o(rstN));

	mips #(.resetPc(bootPc)) dut (
		.clk_i(clk),
		.rstN_i(rstN),
		.instr_i(instr),
		.dataRd_i(dataRd),
		.pcO_o(pcO),
		.memReq_o(memReq)
	);

	bind mips mipsAsserts uAsserts (.clk_i(clk_i), .rstN_i(rstN_i), .memReq_i(memReq_o),
		.stall_i(stall), .flush_i(flush), .pc_i(pc), .target_i(branchTarget),
		.idEx_i(idEx));

	// Fetch beyond the array returns nops
	assign instr = (pcO < 32'd256) ? imem[pcO[7:2]] : '0;
	assign dataRd = dmem[memReq.addr[7:2]];

	function automatic mipsPkg::wordT fillWord(int idx);
		return {16'hC0DE, 8'(idx), 8'(idx) ^ 8'h5A};
	endfunction

	always @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < 64; i++)
				dmem[i] <= fillWord(i);
		end else if (memReq.write) begin
			dmem[memReq.addr[7:2]] <= memReq.wdata;
		end
	end

	function automatic mipsPkg::wordT encodeR(mipsPkg::functE fn, mipsPkg::regIdxT rd,
		mipsPkg::regIdxT rs, mipsPkg::regIdxT rt);
		return {mipsPkg::opRType, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic mipsPkg::wordT encodeI(mipsPkg::opcodeE op, mipsPkg::regIdxT rt,
		mipsPkg::regIdxT rs, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic emit(mipsPkg::wordT w);
		imem[6'(bootIdx + progLen)] = w;
		progLen++;
	endtask

	// Each store goes to its own word in the upper half
	task automatic storeReg(mipsPkg::regIdxT r);
		emit(encodeI(mipsPkg::opSw, r, 5'd0, 16'(storeSlot)));
		storeSlot += 4;
	endtask

	task automatic buildProgram();
		mipsPkg::regIdxT rd;
		mipsPkg::regIdxT prev;
		for (int i = 0; i < 64; i++)
			imem[i] = '0;
		// Random seeds in r1 to r6 through lui and ori
		for (int r = 1; r <= 6; r++) begin
			emit(encodeI(mipsPkg::opLui, mipsPkg::regIdxT'(r), 5'd0, 16'($urandom)));
			emit(encodeI(mipsPkg::opOri, mipsPkg::regIdxT'(r), mipsPkg::regIdxT'(r),
				16'($urandom)));
		end
		emit(encodeI(mipsPkg::opAddiu, 5'd7, 5'd1, 16'($urandom) | 16'h8000));
		storeReg(5'd7);
		emit(encodeI(mipsPkg::opOri, 5'd7, 5'd2, 16'($urandom) | 16'h8000));
		storeReg(5'd7);
		emit(encodeI(mipsPkg::opLui, 5'd7, 5'd0, 16'($urandom)));
		storeReg(5'd7);
		// Dependent ALU chain at distance one and two
		prev = 5'd1;
		for (int i = 0; i < 10; i++) begin
			rd = mipsPkg::regIdxT'(1 + $urandom_range(5));
			emit(encodeR(fnList[3'($urandom_range(4))], rd, prev,
				mipsPkg::regIdxT'(1 + $urandom_range(5))));
			if (i % 2 == 1)
				storeReg(rd);
			prev = rd;
		end
		for (int r = 1; r <= 6; r++)
			storeReg(mipsPkg::regIdxT'(r));
		// Store then load back and use the loaded value at once
		emit(encodeI(mipsPkg::opSw, 5'd3, 5'd0, 16'd64));
		emit(encodeI(mipsPkg::opLw, 5'd9, 5'd0, 16'd64));
		emit(encodeR(mipsPkg::fnAddu, 5'd10, 5'd9, 5'd1));
		storeReg(5'd10);
		emit(encodeI(mipsPkg::opLw, 5'd11, 5'd0, 16'd12));
		storeReg(5'd11);
		// Not-taken beq then a taken one skipping two
		emit(encodeI(mipsPkg::opAddiu, 5'd12, 5'd0, 16'd1));
		emit(encodeI(mipsPkg::opBeq, 5'd0, 5'd12, 16'd2));
		storeReg(5'd12);
		emit(encodeI(mipsPkg::opBeq, 5'd12, 5'd12, 16'd2));
		emit(encodeI(mipsPkg::opAddiu, 5'd13, 5'd0, 16'h7777));
		storeReg(5'd12);
		storeReg(5'd13);
		// r0 stays zero
		emit(encodeI(mipsPkg::opAddiu, 5'd0, 5'd0, 16'h1234));
		storeReg(5'd0);
		emit(encodeR(mipsPkg::fnAddu, 5'd0, 5'd1, 5'd2));
		emit(encodeR(mipsPkg::fnOr, 5'd14, 5'd0, 5'd0));
		storeReg(5'd14);
	endtask

	// Sequential ISA model, one instruction at a time
	function automatic reqListT runIsa();
		mipsPkg::wordT regs [32];
		mipsPkg::wordT mem [64];
		mipsPkg::wordT pc;
		mipsPkg::wordT ins;
		mipsPkg::wordT a;
		mipsPkg::wordT b;
		mipsPkg::wordT sext;
		mipsPkg::wordT addr;
		mipsPkg::regIdxT rt;
		mipsPkg::regIdxT rd;
		mipsPkg::memReqT st;
		reqListT stores;
		int steps;
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		for (int i = 0; i < 64; i++)
			mem[i] = fillWord(i);
		pc = bootPc;
		steps = 0;
		while (pc >= bootPc && pc < bootPc + 32'(4 * progLen) && steps < 500) begin
			ins = imem[pc[7:2]];
			rt = ins[20:16];
			rd = ins[15:11];
			a = regs[ins[25:21]];
			b = regs[rt];
			sext = {{16{ins[15]}}, ins[15:0]};
			addr = a + sext;
			pc = pc + 32'd4;
			case (ins[31:26])
				mipsPkg::opRType: begin
					case (ins[5:0])
						mipsPkg::fnAddu: regs[rd] = a + b;
						mipsPkg::fnSubu: regs[rd] = a - b;
						mipsPkg::fnAnd: regs[rd] = a & b;
						mipsPkg::fnOr: regs[rd] = a | b;
						mipsPkg::fnSlt: regs[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: ;
					endcase
				end
				mipsPkg::opAddiu: regs[rt] = addr;
				mipsPkg::opOri: regs[rt] = a | {16'h0, ins[15:0]};
				mipsPkg::opLui: regs[rt] = {ins[15:0], 16'h0};
				mipsPkg::opLw: regs[rt] = mem[addr[7:2]];
				mipsPkg::opSw: begin
					st.write = 1'b1;
					st.addr = addr;
					st.wdata = b;
					stores.push_back(st);
					mem[addr[7:2]] = b;
				end
				mipsPkg::opBeq: begin
					if (a == b)
						pc = pc + {sext[29:0], 2'b00};
				end
				default: ;
			endcase
			regs[0] = '0;
			steps++;
		end
		return stores;
	endfunction

	task automatic checkStore(mipsPkg::memReqT got, mipsPkg::memReqT exp);
		if (got !== exp) begin
			mismatches++;
			$display("Mismatch at %0t ns: store addr %h data %h, expected addr %h data %h",
				$time, got.addr, got.wdata, exp.addr, exp.wdata);
		end
	endtask

	task automatic checkPc(mipsPkg::wordT got, mipsPkg::wordT exp);
		if (got !== exp) begin
			mismatches++;
			$display("Mismatch at %0t ns: fetch address %h, expected %h", $time, got, exp);
		end
	endtask

	// Compare each DUT store with the next expected one
	always @(negedge clk) begin
		if (rstN && memReq.write) begin
			storesSeen++;
			if (expQ.size() == 0) begin
				otherErrors++;
				$display("Store to address %h at %0t ns was not expected", memReq.addr, $time);
			end else begin
				checkStore(memReq, expQ.pop_front());
			end
		end
	end

	initial begin
		@(posedge rstN);
		repeat (20 * progLen) @(posedge clk);
		$display("Timeout after %0d cycles, the program never finished", 20 * progLen);
		$display("Test failed");
		$finish;
	end

	initial begin
		void'($urandom(92));
		buildProgram();
		expQ = runIsa();
		expCount = expQ.size();
		@(posedge rstN);
		@(negedge clk);
		checkPc(pcO, bootPc);
		wait (storesSeen == expCount);
		// Drain so that late extra stores are caught
		repeat (8) @(negedge clk);
		if (storesSeen != expCount) begin
			otherErrors++;
			$display("DUT made %0d stores, the program makes %0d", storesSeen, expCount);
		end
		$display("Stores %0d, mismatches %0d, other errors %0d", storesSeen, mismatches,
			otherErrors);
		if (mismatches == 0 && otherErrors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- tb.f
design/mipsPkg.sv
design/decoder.sv
design/regFile.sv
design/hazardUnit.sv
design/forwardUnit.sv
design/alu.sv
design/mips.sv
sim/clockGen.sv
sim/mipsAsserts.sv
sim/tbMips.sv
